//--- tb.f
+incdir+.
pagerank_pkg.sv
pr_config_regs.sv
rank_sched.sv
rank_operand_feed.sv
rank_mac_lane.sv
rank_accum.sv
pagerank_top.sv
tb_pagerank_mem.sv
tb_pagerank.sv

//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module tb_pagerank -f tb.f -o Vtb_pagerank

run: build
	./obj_dir/Vtb_pagerank | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
	  --top-module pagerank_top -f tb.f

clean:
	rm -rf obj_dir $(LOG)

//--- tb_pagerank.sv
// ------------------------------
// three runs, nround 1, 3 and 0, on random memory
// bases below 1 KB, regions of the runs kept apart
// ------------------------------
`include "pagerank_params.svh"

module tb_pagerank;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_LAT = 5;
  // matrix reads of rounds 1 + 3 + 0, plus 4 rank accesses per run
  localparam int N_REQ = (1 + 3 + 0) * 16 + 3 * 4;
  localparam int WD_CYCLES = N_REQ * (MAX_LAT + 8) + 400;

  logic                    clk = 1'b0;
  logic                    reset;
  pagerank_pkg::pr_req_t   pr_req;
  logic                    pr_req_val;
  logic                    pr_req_rdy;
  pagerank_pkg::pr_resp_t  pr_resp;
  logic                    pr_resp_val;
  logic                    pr_resp_rdy;
  pagerank_pkg::mem_req_t  mem_req;
  logic                    mem_req_val;
  logic                    mem_req_rdy;
  pagerank_pkg::mem_resp_t mem_resp;
  logic                    mem_resp_val;
  logic                    mem_resp_rdy;
  int                      max_lat;
  logic                    gaps;

  string       test_name;
  int          checks = 0;
  int          value_errs = 0;
  int          proto_errs = 0;
  logic [31:0] exp_base_r;
  logic [31:0] exp_lo;
  logic [31:0] exp_hi;
  int          wr_seen = 0;
  int          wr_done = 0;
  logic        run_active = 1'b0;
  // memory request accepted, response not yet taken
  logic        mem_pend = 1'b0;

  always #4 clk = ~clk;

  pagerank_top u_pagerank_top (.*);

  tb_pagerank_mem u_mem (.*);

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return u_mem.mem[addr[9:2]];
  endfunction

  // next[i] = sum of g[i][j] * r[j], mod 256, repeated nr times
  function automatic logic [63:0] model_rounds(input logic [31:0] bg, input logic [31:0] br,
                                               input int nr);
    logic [7:0]  cur [`PR_N];
    logic [7:0]  nxt [`PR_N];
    logic [7:0]  g;
    logic [31:0] w;
    for (int j = 0; j < `PR_N; j++) begin
      w      = word_at(br + 32'(4 * (j / 4)));
      cur[j] = w[8 * (j % 4) +: 8];
    end
    for (int n = 0; n < nr; n++) begin
      for (int i = 0; i < `PR_N; i++) begin
        nxt[i] = 8'd0;
        for (int j = 0; j < `PR_N; j++) begin
          // row i lives at bg + 8i, columns 4-7 in the second word
          w      = word_at(bg + 32'(`PR_ROW_STRIDE * i + 4 * (j / 4)));
          g      = w[8 * (j % 4) +: 8];
          nxt[i] = nxt[i] + g * cur[j];
        end
      end
      cur = nxt;
    end
    return {cur[7], cur[6], cur[5], cur[4], cur[3], cur[2], cur[1], cur[0]};
  endfunction

  // ------------------------------
  // host stimulus
  // ------------------------------
  // called on a falling edge, returns on one with val low
  task automatic host_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    pr_req.wr   = wr;
    pr_req.addr = addr;
    pr_req.data = data;
    pr_req_val  = 1'b1;
    @(posedge clk);
    while (!pr_req_rdy) @(posedge clk);
    @(negedge clk);
    pr_req_val = 1'b0;
  endtask

  task automatic run_case(input string name, input logic [31:0] bg, input logic [31:0] br,
                          input int nr, input int lat, input logic gap);
    logic [63:0] vec;
    test_name  = name;
    max_lat    = lat;
    gaps       = gap;
    vec        = model_rounds(bg, br, nr);
    exp_base_r = br;
    exp_lo     = vec[31:0];
    exp_hi     = vec[63:32];
    host_xfer(1'b1, `PR_ADDR_BASE_G, bg);
    host_xfer(1'b1, `PR_ADDR_BASE_R, br);
    host_xfer(1'b1, `PR_ADDR_NROUND, 32'(nr));
    host_xfer(1'b0, `PR_ADDR_NROUND, 32'd0);
    host_xfer(1'b1, `PR_ADDR_GO, 32'd0);
    // held through the run, taken once the engine is idle again
    host_xfer(1'b0, `PR_ADDR_GO, 32'd0);
  endtask

  // host response back-pressure
  initial begin
    pr_resp_rdy = 1'b0;
    forever begin
      @(negedge clk);
      pr_resp_rdy = ($urandom % 4) != 0;
    end
  end

  initial begin
    reset      = 1'b1;
    pr_req     = '0;
    pr_req_val = 1'b0;
    max_lat    = 0;
    gaps       = 1'b0;
    test_name  = "reset";
    void'($urandom(32'hcf1a));
    repeat (3) @(negedge clk);
    reset = 1'b0;
    run_case("one_round", 32'h000, 32'h200, 1, 0, 1'b0);
    run_case("three_rounds", 32'h080, 32'h210, 3, MAX_LAT, 1'b1);
    run_case("zero_rounds", 32'h100, 32'h220, 0, 2, 1'b1);
    @(negedge clk);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // sized from the request count, worst latency and gaps
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // checks
  // ------------------------------
  always @(posedge clk) begin
    if (!reset) begin
      // host response, same cycle as the request
      if (pr_req_val && pr_req_rdy) begin
        checks += 3;
        assert (pr_resp_val) else begin
          proto_errs++;
          $display("host request taken without a response in %s", test_name);
        end
        assert (pr_resp.wr == pr_req.wr) else begin
          value_errs++;
          $display("Error %s resp wr: expected %b actual %b", test_name, pr_req.wr, pr_resp.wr);
        end
        assert (pr_resp.data == (pr_req.wr ? 32'd0 : 32'd1)) else begin
          value_errs++;
          $display("Error %s resp data: expected %h actual %h", test_name,
                   pr_req.wr ? 32'd0 : 32'd1, pr_resp.data);
        end
        if (pr_req.wr && pr_req.addr == `PR_ADDR_GO) begin
          run_active <= 1'b1;
          wr_seen    <= 0;
          wr_done    <= 0;
        end
      end
      // write-back address and data
      if (mem_req_val && mem_req_rdy && mem_req.wr) begin
        checks += 3;
        assert (wr_seen < 2) else begin
          proto_errs++;
          $display("more than two write-backs in %s", test_name);
        end
        assert (mem_req.addr == exp_base_r + 32'(wr_seen * 4)) else begin
          value_errs++;
          $display("Error %s write addr: expected %h actual %h", test_name,
                   exp_base_r + 32'(wr_seen * 4), mem_req.addr);
        end
        assert (mem_req.data.raw == (wr_seen == 0 ? exp_lo : exp_hi)) else begin
          value_errs++;
          $display("Error %s write data: expected %h actual %h", test_name,
                   wr_seen == 0 ? exp_lo : exp_hi, mem_req.data.raw);
        end
        wr_seen <= wr_seen + 1;
      end
      // one request in flight at a time
      if (mem_req_val && mem_req_rdy) mem_pend <= 1'b1;
      if (mem_resp_val && mem_resp_rdy) mem_pend <= 1'b0;
      // second write response ends the run
      if (mem_resp_val && mem_resp_rdy && mem_resp.wr) begin
        if (wr_done == 1) run_active <= 1'b0;
        wr_done <= wr_done + 1;
      end
    end
  end

  a_busy_quiet: assert property (@(posedge clk) disable iff (reset)
    run_active |-> !pr_req_rdy && !pr_resp_val)
    else begin
      proto_errs++;
      $display("host port ready or answering during a run in %s", test_name);
    end

  a_idle_rule: assert property (@(posedge clk) disable iff (reset)
    !run_active |-> pr_req_rdy == pr_resp_rdy && pr_resp_val == pr_req_val)
    else begin
      proto_errs++;
      $display("host port not following the idle handshake in %s", test_name);
    end

  a_req_held: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
    else begin
      proto_errs++;
      $display("memory request changed while held in %s", test_name);
    end

  // response ready only while a request waits, and no new request then
  a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    mem_pend ? (mem_resp_rdy && !mem_req_val) : !mem_resp_rdy)
    else begin
      proto_errs++;
      $display("memory response ready not matching the request in flight in %s", test_name);
    end

endmodule

//--- tb_pagerank_mem.sv
// ------------------------------
// word memory, 256 words, byte address bits 9:2
// one request at a time, random latency and ready gaps
// ------------------------------
`include "pagerank_params.svh"

module tb_pagerank_mem (
  input  logic                    clk,
  input  logic                    reset,
  input  pagerank_pkg::mem_req_t  mem_req,
  input  logic                    mem_req_val,
  output logic                    mem_req_rdy,
  output pagerank_pkg::mem_resp_t mem_resp,
  output logic                    mem_resp_val,
  input  logic                    mem_resp_rdy,
  input  int                      max_lat,
  input  logic                    gaps
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`PR_WORD_W-1:0]   mem [256];
  logic                    pend;
  int                      cycle;
  int                      ready_at;
  pagerank_pkg::mem_resp_t resp_q;

  // accept side, sampled on the rising edge
  initial begin
    pend     = 1'b0;
    cycle    = 0;
    ready_at = 0;
    resp_q   = '0;
    // fill after the seed is set at time 0
    @(posedge clk);
    for (int a = 0; a < 256; a++) begin
      mem[a] = $urandom;
    end
    forever begin
      @(posedge clk);
      cycle++;
      if (mem_resp_val && mem_resp_rdy) pend = 1'b0;
      if (mem_req_val && mem_req_rdy) begin
        resp_q.wr = mem_req.wr;
        if (mem_req.wr) begin
          mem[mem_req.addr[9:2]] = mem_req.data.raw;
          resp_q.data.raw        = '0;
        end else begin
          resp_q.data.raw = mem[mem_req.addr[9:2]];
        end
        pend     = 1'b1;
        ready_at = cycle + int'($urandom_range(max_lat, 0));
      end
    end
  end

  // drive side, falling edge only
  initial begin
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    forever begin
      @(negedge clk);
      // gaps drop ready on about one cycle in three
      mem_req_rdy  = !pend && !reset && (!gaps || ($urandom % 3) != 0);
      mem_resp_val = pend && cycle >= ready_at;
      mem_resp     = mem_resp_val ? resp_q : '0;
    end
  end

endmodule

//--- pagerank_top.sv
// ------------------------------
// host config port plus one memory port
// ------------------------------
`include "pagerank_params.svh"

module pagerank_top (
  input  logic                    clk,
  input  logic                    reset,
  input  pagerank_pkg::pr_req_t   pr_req,
  input  logic                    pr_req_val,
  output logic                    pr_req_rdy,
  output pagerank_pkg::pr_resp_t  pr_resp,
  output logic                    pr_resp_val,
  input  logic                    pr_resp_rdy,
  output pagerank_pkg::mem_req_t  mem_req,
  output logic                    mem_req_val,
  input  logic                    mem_req_rdy,
  input  pagerank_pkg::mem_resp_t mem_resp,
  input  logic                    mem_resp_val,
  output logic                    mem_resp_rdy
);

  logic                                     busy;
  logic                                     go;
  logic [31:0]                              base_g;
  logic [31:0]                              base_r;
  logic [31:0]                              nround;
  logic                                     rank_load_valid;
  logic                                     rank_load_half;
  logic                                     round_swap;
  logic                                     rd_half;
  pagerank_pkg::lane_ctl_t                  sched_ctl;
  pagerank_pkg::lane_ctl_t                  feed_ctl;
  pagerank_pkg::lane_ctl_t                  lane_ctl [`PR_LANES];
  pagerank_pkg::data_word_u                 r_word;
  pagerank_pkg::rank_byte_t [`PR_LANES-1:0] g_byte;
  pagerank_pkg::rank_byte_t [`PR_LANES-1:0] r_byte;
  pagerank_pkg::rank_byte_t [`PR_LANES-1:0] product;
  logic                                     result_valid;
  logic [2:0]                               result_row;
  pagerank_pkg::rank_byte_t                 result_byte;

  pr_config_regs u_config (
    .clk, .reset,
    .pr_req, .pr_req_val, .pr_req_rdy,
    .pr_resp, .pr_resp_val, .pr_resp_rdy,
    .busy, .go, .base_g, .base_r, .nround
  );

  rank_sched u_sched (
    .clk, .reset, .go, .base_g, .base_r, .nround, .busy,
    .mem_req, .mem_req_val, .mem_req_rdy,
    .mem_resp, .mem_resp_val, .mem_resp_rdy,
    .r_word, .result_valid,
    .rank_load_valid, .rank_load_half,
    .lane_ctl   (sched_ctl),
    .round_swap, .rd_half
  );

  rank_operand_feed u_feed (
    .clk, .reset,
    .mem_data     (mem_resp.data),
    .rank_load_valid, .rank_load_half,
    .lane_ctl_in  (sched_ctl),
    .round_swap, .result_valid, .result_row, .result_byte, .rd_half,
    .g_byte, .r_byte,
    .lane_ctl_out (feed_ctl),
    .r_word
  );

  // one lane per byte of a matrix word
  for (genvar k = 0; k < `PR_LANES; k++) begin : g_lane
    rank_mac_lane u_lane (
      .clk, .reset,
      .g_byte  (g_byte[k]),
      .r_byte  (r_byte[k]),
      .ctl_in  (feed_ctl),
      .product (product[k]),
      .ctl_out (lane_ctl[k])
    );
  end

  // lanes run in lockstep, lane 0 tag is enough
  rank_accum u_accum (
    .clk, .reset, .product,
    .ctl (lane_ctl[0]),
    .result_valid, .result_row, .result_byte
  );

endmodule

//--- rank_accum.sv
// ------------------------------
// expects half 0 then half 1 of each row
// ------------------------------
`include "pagerank_params.svh"

module rank_accum (
  input  logic                                     clk,
  input  logic                                     reset,
  input  pagerank_pkg::rank_byte_t [`PR_LANES-1:0] product,
  input  pagerank_pkg::lane_ctl_t                  ctl,
  output logic                                     result_valid,
  output logic [2:0]                               result_row,
  output pagerank_pkg::rank_byte_t                 result_byte
);

  pagerank_pkg::rank_byte_t sum;
  pagerank_pkg::rank_byte_t partial;
  logic [2:0]               pend_row;
  logic                     pend;

  // lane sum, wraps at 256
  always_comb begin
    sum = '0;
    for (int k = 0; k < `PR_LANES; k++) begin
      sum = sum + product[k];
    end
  end

  // half 0 parks its partial sum
  always_ff @(posedge clk) begin
    if (reset) begin
      partial  <= '0;
      pend_row <= '0;
      pend     <= 1'b0;
    end else if (ctl.valid) begin
      if (!ctl.half) begin
        partial  <= sum;
        pend_row <= ctl.row;
        pend     <= 1'b1;
      end else begin
        pend <= 1'b0;
      end
    end
  end

  // half 1 completes the row this cycle
  assign result_valid = ctl.valid && ctl.half;
  assign result_row   = ctl.row;
  assign result_byte  = partial + sum;

  // halves of a row arrive in order
  a_half_order: assert property (@(posedge clk) disable iff (reset)
    ctl.valid && ctl.half |-> pend && pend_row == ctl.row);

endmodule

//--- rank_mac_lane.sv
// ------------------------------
// 8x8 multiply, result kept modulo 256
// ------------------------------

module rank_mac_lane (
  input  logic                     clk,
  input  logic                     reset,
  input  pagerank_pkg::rank_byte_t g_byte,
  input  pagerank_pkg::rank_byte_t r_byte,
  input  pagerank_pkg::lane_ctl_t  ctl_in,
  output pagerank_pkg::rank_byte_t product,
  output pagerank_pkg::lane_ctl_t  ctl_out
);

  // 8 bit context drops the upper product bits
  pagerank_pkg::rank_byte_t mul;

  assign mul = g_byte * r_byte;

  // product and its tag move together
  always_ff @(posedge clk) begin
    if (reset) begin
      product <= '0;
      ctl_out <= '0;
    end else begin
      product <= mul;
      ctl_out <= ctl_in;
    end
  end

endmodule

//--- rank_operand_feed.sv
// ------------------------------
// ping-pong rank banks, 8 entries each
// loads go to current bank, results to next
// ------------------------------
`include "pagerank_params.svh"

module rank_operand_feed (
  input  logic                                        clk,
  input  logic                                        reset,
  input  pagerank_pkg::data_word_u                    mem_data,
  input  logic                                        rank_load_valid,
  input  logic                                        rank_load_half,
  input  pagerank_pkg::lane_ctl_t                     lane_ctl_in,
  input  logic                                        round_swap,
  input  logic                                        result_valid,
  input  logic [2:0]                                  result_row,
  input  pagerank_pkg::rank_byte_t                    result_byte,
  input  logic                                        rd_half,
  output pagerank_pkg::rank_byte_t [`PR_LANES-1:0]    g_byte,
  output pagerank_pkg::rank_byte_t [`PR_LANES-1:0]    r_byte,
  output pagerank_pkg::lane_ctl_t                     lane_ctl_out,
  output pagerank_pkg::data_word_u                    r_word
);

  pagerank_pkg::rank_byte_t [`PR_N-1:0] bank [2];

  // selects the current bank, the other one is next
  logic cur;

  // ------------------------------
  // bank update
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cur     <= 1'b0;
      bank[0] <= '0;
      bank[1] <= '0;
    end else begin
      if (rank_load_valid) begin
        for (int k = 0; k < `PR_LANES; k++) begin
          bank[cur][rank_load_half * `PR_LANES + k] <= mem_data.bytes[k];
        end
      end
      if (result_valid) begin
        bank[!cur][result_row] <= result_byte;
      end
      if (round_swap) begin
        cur <= !cur;
      end
    end
  end

  // ------------------------------
  // operands and write data
  // ------------------------------
  always_comb begin
    for (int k = 0; k < `PR_LANES; k++) begin
      // matrix bytes come straight off the response
      g_byte[k] = mem_data.bytes[k];
      // rank half picked by the matrix word's half
      r_byte[k] = bank[cur][lane_ctl_in.half * `PR_LANES + k];
      // write-back word for the half being stored
      r_word.bytes[k] = bank[cur][rd_half * `PR_LANES + k];
    end
  end

  assign lane_ctl_out = lane_ctl_in;

  // swap waits for the last row to land
  a_no_swap_on_write: assert property (@(posedge clk) disable iff (reset)
    !(result_valid && round_swap));

endmodule

//--- rank_sched.sv
// ------------------------------
// one memory request in flight at a time
// nround 0 writes the loaded vector straight back
// ------------------------------
`include "pagerank_params.svh"

module rank_sched (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      go,
  input  logic [31:0]               base_g,
  input  logic [31:0]               base_r,
  input  logic [31:0]               nround,
  output logic                      busy,
  output pagerank_pkg::mem_req_t    mem_req,
  output logic                      mem_req_val,
  input  logic                      mem_req_rdy,
  input  pagerank_pkg::mem_resp_t   mem_resp,
  input  logic                      mem_resp_val,
  output logic                      mem_resp_rdy,
  input  pagerank_pkg::data_word_u  r_word,
  input  logic                      result_valid,
  output logic                      rank_load_valid,
  output logic                      rank_load_half,
  output pagerank_pkg::lane_ctl_t   lane_ctl,
  output logic                      round_swap,
  output logic                      rd_half
);

  localparam int WORD_BYTES = `PR_WORD_W / `PR_BYTE_W;

  pagerank_pkg::sched_state_t state;
  pagerank_pkg::sched_state_t state_next;

  logic [2:0]  row;
  logic        half;
  logic [31:0] round_cnt;
  logic        wait_cnt;
  logic        req_go;
  logic        resp_go;
  logic        last_round;
  logic [31:0] r_addr;
  logic [31:0] g_addr;

  assign req_go  = mem_req_val && mem_req_rdy;
  assign resp_go = mem_resp_val && mem_resp_rdy;

  assign last_round = (round_cnt + 32'd1 == nround);

  // word address from base, row and half
  assign r_addr = base_r + 32'(half) * WORD_BYTES;
  assign g_addr = base_g + 32'(row) * `PR_ROW_STRIDE + 32'(half) * WORD_BYTES;

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      pagerank_pkg::st_idle:
        if (go) state_next = pagerank_pkg::st_load_r;
      pagerank_pkg::st_load_r:
        if (req_go) state_next = pagerank_pkg::st_wait_r;
      pagerank_pkg::st_wait_r:
        if (resp_go) begin
          if (!half)
            state_next = pagerank_pkg::st_load_r;
          else if (nround == 32'd0)
            state_next = pagerank_pkg::st_write_r;
          else
            state_next = pagerank_pkg::st_read_g;
        end
      pagerank_pkg::st_read_g:
        if (req_go) state_next = pagerank_pkg::st_wait_g;
      pagerank_pkg::st_wait_g:
        if (resp_go) begin
          // row 7 half 1 closes the round
          if (half && row == 3'd7)
            state_next = pagerank_pkg::st_next_round;
          else
            state_next = pagerank_pkg::st_read_g;
        end
      pagerank_pkg::st_next_round:
        // second hold cycle, last result already in next bank
        if (wait_cnt)
          state_next = last_round ? pagerank_pkg::st_write_r : pagerank_pkg::st_read_g;
      pagerank_pkg::st_write_r:
        if (req_go) state_next = pagerank_pkg::st_wait_w;
      pagerank_pkg::st_wait_w:
        if (resp_go)
          state_next = half ? pagerank_pkg::st_idle : pagerank_pkg::st_write_r;
      default:
        state_next = pagerank_pkg::st_idle;
    endcase
  end

  // ------------------------------
  // state and counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= pagerank_pkg::st_idle;
      row       <= '0;
      half      <= 1'b0;
      round_cnt <= '0;
      wait_cnt  <= 1'b0;
    end else begin
      state <= state_next;
      case (state)
        pagerank_pkg::st_idle:
          if (go) begin
            row       <= '0;
            half      <= 1'b0;
            round_cnt <= '0;
            wait_cnt  <= 1'b0;
          end
        pagerank_pkg::st_wait_r,
        pagerank_pkg::st_wait_w:
          if (resp_go) half <= !half;
        pagerank_pkg::st_wait_g:
          if (resp_go) begin
            half <= !half;
            // row wraps to 0 after row 7
            if (half) row <= row + 3'd1;
          end
        pagerank_pkg::st_next_round: begin
          wait_cnt <= !wait_cnt;
          if (wait_cnt) round_cnt <= round_cnt + 32'd1;
        end
        default: ;
      endcase
    end
  end

  // ------------------------------
  // memory port
  // ------------------------------
  always_comb begin
    mem_req          = '0;
    mem_req.data.raw = '0;
    mem_req_val      = 1'b0;
    mem_resp_rdy     = 1'b0;
    case (state)
      pagerank_pkg::st_load_r: begin
        mem_req_val  = 1'b1;
        mem_req.addr = r_addr;
      end
      pagerank_pkg::st_read_g: begin
        mem_req_val  = 1'b1;
        mem_req.addr = g_addr;
      end
      pagerank_pkg::st_write_r: begin
        mem_req_val  = 1'b1;
        mem_req.wr   = 1'b1;
        mem_req.addr = r_addr;
        mem_req.data = r_word;
      end
      pagerank_pkg::st_wait_r,
      pagerank_pkg::st_wait_g,
      pagerank_pkg::st_wait_w:
        mem_resp_rdy = 1'b1;
      default: ;
    endcase
  end

  // datapath strobes
  assign busy            = (state != pagerank_pkg::st_idle);
  assign rank_load_valid = (state == pagerank_pkg::st_wait_r) && resp_go;
  assign rank_load_half  = half;
  assign lane_ctl.valid  = (state == pagerank_pkg::st_wait_g) && resp_go;
  assign lane_ctl.half   = half;
  assign lane_ctl.row    = row;
  assign round_swap      = (state == pagerank_pkg::st_next_round) && wait_cnt;
  assign rd_half         = half;

  // held request must not move
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req));

  // lanes plus accumulator take exactly two cycles
  a_last_result: assert property (@(posedge clk) disable iff (reset)
    state == pagerank_pkg::st_next_round && !wait_cnt |-> result_valid);

endmodule

//--- pr_config_regs.sv
// ------------------------------
// host port only accepts while the engine is idle
// ------------------------------
`include "pagerank_params.svh"

module pr_config_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  pagerank_pkg::pr_req_t  pr_req,
  input  logic                   pr_req_val,
  output logic                   pr_req_rdy,
  output pagerank_pkg::pr_resp_t pr_resp,
  output logic                   pr_resp_val,
  input  logic                   pr_resp_rdy,
  input  logic                   busy,
  output logic                   go,
  output logic [31:0]            base_g,
  output logic [31:0]            base_r,
  output logic [31:0]            nround
);

  logic req_go;
  logic wr_go;

  // ------------------------------
  // idle handshake
  // ------------------------------

  // request and response move together in one cycle
  assign pr_req_rdy  = !busy && pr_resp_rdy;
  assign pr_resp_val = !busy && pr_req_val;

  assign req_go = pr_req_val && pr_req_rdy;
  assign wr_go  = req_go && pr_req.wr;

  // writes answer 0, reads answer 1
  assign pr_resp.wr   = pr_req.wr;
  assign pr_resp.data = pr_req.wr ? 32'd0 : 32'd1;

  // start pulse, one cycle wide
  assign go = wr_go && (pr_req.addr == `PR_ADDR_GO);

  // ------------------------------
  // config registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
      nround <= '0;
    end else if (wr_go) begin
      // unknown addresses are answered but ignored
      case (pr_req.addr)
        `PR_ADDR_BASE_G: base_g <= pr_req.data;
        `PR_ADDR_BASE_R: base_r <= pr_req.data;
        `PR_ADDR_NROUND: nround <= pr_req.data;
        default: ;
      endcase
    end
  end

endmodule

//--- pagerank_pkg.sv
// ------------------------------
// shared message and control types
// ------------------------------
`include "pagerank_params.svh"

package pagerank_pkg;

  // one rank entry or matrix weight
  typedef logic [`PR_BYTE_W-1:0] rank_byte_t;

  // memory word, raw or as four bytes (byte 0 in the low bits)
  typedef union packed {
    logic [`PR_WORD_W-1:0]                   raw;
    rank_byte_t [`PR_WORD_W/`PR_BYTE_W-1:0]  bytes;
  } data_word_u;

  // host side messages
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
  } pr_req_t;

  typedef struct packed {
    logic        wr;
    logic [31:0] data;
  } pr_resp_t;

  // memory side messages
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    data_word_u  data;
  } mem_req_t;

  typedef struct packed {
    logic        wr;
    data_word_u  data;
  } mem_resp_t;

  // tag riding along with each matrix word
  typedef struct packed {
    logic       valid;
    logic       half;
    logic [2:0] row;
  } lane_ctl_t;

  typedef enum logic [2:0] {
    st_idle,
    st_load_r,
    st_wait_r,
    st_read_g,
    st_wait_g,
    st_next_round,
    st_write_r,
    st_wait_w
  } sched_state_t;

endpackage

//--- pagerank_params.svh
// ------------------------------
// sizes fixed at build time, 8x8 only
// register addresses are host word indices
// ------------------------------
`ifndef PAGERANK_PARAMS_SVH
`define PAGERANK_PARAMS_SVH

// vector and datapath shape
`define PR_N          8
`define PR_LANES      4
`define PR_BYTE_W     8
`define PR_WORD_W     32

// host register map, go must stay at 0
`define PR_ADDR_GO      32'd0
`define PR_ADDR_BASE_G  32'd1
`define PR_ADDR_BASE_R  32'd2
`define PR_ADDR_NROUND  32'd3

// bytes per matrix row in memory
`define PR_ROW_STRIDE 8

`endif
